//--- files.f
source/usb_line_pkg.sv
source/usb_pkt_pkg.sv
source/usb_bit_if.sv
source/usb_line_fsm.sv
source/usb_bit_timer.sv
source/usb_bit_decoder.sv
source/usb_pkt_checker.sv
source/usb_fs_rx_top.sv
verif/tb_usb_fs_rx.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and fail when the log reports a failure
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_usb_fs_rx \
  -Mdir obj_dir -o tb_usb_fs_rx -f files.f || exit 1
./obj_dir/tb_usb_fs_rx > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

//--- verif/tb_usb_fs_rx.sv
// self-checking testbench for the full-speed receive chain
// packets are NRZI encoded and bit stuffed here and driven on the pair
// the stuffing run counts from the first bit after the sync, as in the receiver
`timescale 1ns/1ps
`default_nettype none

module tb_usb_fs_rx
  import usb_pkt_pkg::*;
();

  localparam int unsigned BIT_CLKS  = 4;
  localparam int unsigned SEED      = 79517;
  localparam int unsigned NUM_PKTS  = 7;
  localparam int unsigned IDLE_BITS = 8;
  localparam int unsigned END_WAIT  = 64 * BIT_CLKS;
  localparam logic [1:0]  LINE_J    = 2'b10;
  localparam logic [1:0]  LINE_SE0  = 2'b00;
  localparam logic [15:0] POLY      = 16'h8005;
  localparam logic [15:0] CRC_START = 16'hFFFF;

  typedef enum logic [1:0] {FAULT_NONE, FAULT_CRC, FAULT_PID, FAULT_STUFF} fault_e;

  // one row of the packet table
  typedef struct packed {
    usb_pid_e   pid;
    logic [7:0] len;
    logic       fill_ones;
    fault_e     fault;
  } pkt_entry_t;

  logic              clk_i;
  logic              rst_ni;
  logic              usb_dp_i;
  logic              usb_dn_i;
  logic              bit_strobe_o;
  logic              pkt_start_o;
  logic              pkt_end_o;
  usb_pid_e          pid_o;
  logic              valid_pid_o;
  logic              valid_packet_o;
  logic              rx_data_put_o;
  logic [BYTE_W-1:0] rx_data_o;
  logic              crc16_error_o;
  logic              pid_error_o;
  logic              bitstuff_error_o;

  pkt_entry_t pkt_table [NUM_PKTS];
  logic       tx_bits [$];
  logic [7:0] exp_bytes [$];
  logic [7:0] got_bytes [$];
  logic [1:0] line_level;
  logic       table_loaded;
  int         errors;
  int         start_cnt;
  int         end_cnt;
  int         strobe_cnt;
  int         sym_cnt;
  usb_pid_e   got_pid;
  logic       got_valid_pid;
  logic       got_valid_pkt;
  logic       got_crc_err;
  logic       got_pid_err;
  logic       got_stuff_err;

  usb_fs_rx_top #(
    .CLKS_PER_BIT (BIT_CLKS)
  ) DUT (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .usb_dp_i         (usb_dp_i),
    .usb_dn_i         (usb_dn_i),
    .bit_strobe_o     (bit_strobe_o),
    .pkt_start_o      (pkt_start_o),
    .pkt_end_o        (pkt_end_o),
    .pid_o            (pid_o),
    .valid_pid_o      (valid_pid_o),
    .valid_packet_o   (valid_packet_o),
    .rx_data_put_o    (rx_data_put_o),
    .rx_data_o        (rx_data_o),
    .crc16_error_o    (crc16_error_o),
    .pid_error_o      (pid_error_o),
    .bitstuff_error_o (bitstuff_error_o)
  );

  always #50 clk_i = ~clk_i;

  // outputs only move on the rising edge, so the falling edge sees them settled
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (bit_strobe_o) begin
        strobe_cnt++;
      end
      if (pkt_start_o) begin
        start_cnt++;
      end
      if (rx_data_put_o) begin
        got_bytes.push_back(rx_data_o);
      end
      if (pkt_end_o) begin
        end_cnt++;
        got_pid       = pid_o;
        got_valid_pid = valid_pid_o;
        got_valid_pkt = valid_packet_o;
        got_crc_err   = crc16_error_o;
        got_pid_err   = pid_error_o;
        got_stuff_err = bitstuff_error_o;
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  // the bad PID row flips one bit of the upper nibble
  task automatic load_table();
    pkt_table[0] = '{pid: PID_ACK,   len: 8'd0, fill_ones: 1'b0, fault: FAULT_NONE};
    pkt_table[1] = '{pid: PID_DATA0, len: 8'd8, fill_ones: 1'b0, fault: FAULT_NONE};
    pkt_table[2] = '{pid: PID_DATA1, len: 8'd3, fill_ones: 1'b0, fault: FAULT_NONE};
    pkt_table[3] = '{pid: PID_DATA0, len: 8'd5, fill_ones: 1'b0, fault: FAULT_CRC};
    pkt_table[4] = '{pid: PID_NAK,   len: 8'd0, fill_ones: 1'b0, fault: FAULT_PID};
    pkt_table[5] = '{pid: PID_DATA0, len: 8'd4, fill_ones: 1'b1, fault: FAULT_NONE};
    pkt_table[6] = '{pid: PID_DATA0, len: 8'd4, fill_ones: 1'b1, fault: FAULT_STUFF};
  endtask

  // PID, payload and CRC16 in line order with each byte LSB first
  task automatic build_packet(input pkt_entry_t e);
    logic [7:0]  pid_byte;
    logic [7:0]  data;
    logic [15:0] crc;
    logic [15:0] crc_field;
    logic        fb;
    tx_bits.delete();
    exp_bytes.delete();
    pid_byte = {~e.pid, e.pid};
    if (e.fault == FAULT_PID) begin
      pid_byte[4] = ~pid_byte[4];
    end
    for (int k = 0; k < 8; k++) begin
      tx_bits.push_back(pid_byte[k]);
    end
    if (e.pid[1:0] == 2'b11) begin
      crc = CRC_START;
      for (int n = 0; n < int'(e.len); n++) begin
        data = e.fill_ones ? 8'hFF : 8'($urandom());
        exp_bytes.push_back(data);
        for (int k = 0; k < 8; k++) begin
          tx_bits.push_back(data[k]);
          fb  = data[k] ^ crc[15];
          crc = {crc[14:0], 1'b0} ^ (fb ? POLY : 16'h0000);
        end
      end
      // the register goes out inverted with its top bit first
      for (int k = 0; k < 16; k++) begin
        crc_field[k] = ~crc[15-k];
      end
      if (e.fault == FAULT_CRC) begin
        crc_field[0] = ~crc_field[0];
      end
      exp_bytes.push_back(crc_field[7:0]);
      exp_bytes.push_back(crc_field[15:8]);
      for (int k = 0; k < 16; k++) begin
        tx_bits.push_back(crc_field[k]);
      end
    end
  endtask

  // every symbol that goes out is counted for the bit strobe check
  task automatic drive_symbol(input logic [1:0] sym);
    {usb_dp_i, usb_dn_i} = sym;
    sym_cnt++;
    repeat (BIT_CLKS) @(negedge clk_i);
  endtask

  // NRZI encoding toggles between J and K on a zero and holds the level on a one
  task automatic send_bit(input logic b);
    if (!b) begin
      line_level = ~line_level;
    end
    drive_symbol(line_level);
  endtask

  task automatic send_packet(input logic do_stuff);
    int ones;
    ones = 0;
    line_level = LINE_J;
    for (int k = 0; k < 8; k++) begin
      send_bit(k == 7);
    end
    foreach (tx_bits[k]) begin
      send_bit(tx_bits[k]);
      ones = tx_bits[k] ? ones + 1 : 0;
      if (do_stuff && ones == 6) begin
        send_bit(1'b0);
        ones = 0;
      end
    end
    // EOP is two SE0 bits and a J
    drive_symbol(LINE_SE0);
    drive_symbol(LINE_SE0);
    drive_symbol(LINE_J);
    line_level = LINE_J;
  endtask

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic clear_results();
    start_cnt  = 0;
    end_cnt    = 0;
    strobe_cnt = 0;
    sym_cnt    = 0;
    got_bytes.delete();
    got_pid       = PID_RSVD;
    got_valid_pid = 1'b0;
    got_valid_pkt = 1'b0;
    got_crc_err   = 1'b0;
    got_pid_err   = 1'b0;
    got_stuff_err = 1'b0;
  endtask

  task automatic wait_for_end(input int idx);
    int waited;
    waited = 0;
    while (end_cnt == 0 && waited < int'(END_WAIT)) begin
      @(negedge clk_i);
      waited++;
    end
    if (end_cnt == 0) begin
      errors++;
      $display("packet %0d never reached its end of packet within %0d clocks", idx, END_WAIT);
    end
  endtask

  // expected results follow the PID type, the length and the injected fault
  task automatic check_packet(input pkt_entry_t e);
    logic pid_ok;
    logic is_hs;
    logic is_data;
    logic exp_valid;
    pid_ok    = (e.fault != FAULT_PID);
    is_hs     = (e.pid[1:0] == 2'b10);
    is_data   = (e.pid[1:0] == 2'b11);
    exp_valid = pid_ok && (e.fault != FAULT_STUFF) &&
                ((is_hs && e.len == 0) || (is_data && e.fault != FAULT_CRC));
    // bits last four clocks, so the timer strobes once per driven symbol
    check_value("bit_strobe_o count", 32'(strobe_cnt), 32'(sym_cnt));
    check_value("pkt_start_o count", 32'(start_cnt), 32'd1);
    check_value("pkt_end_o count", 32'(end_cnt), 32'd1);
    check_value("pid_o", 32'(got_pid), 32'(e.pid));
    check_value("valid_pid_o", 32'(got_valid_pid), 32'(pid_ok));
    check_value("valid_packet_o", 32'(got_valid_pkt), 32'(exp_valid));
    check_value("pid_error_o", 32'(got_pid_err), 32'(!pid_ok));
    check_value("bitstuff_error_o", 32'(got_stuff_err), 32'(e.fault == FAULT_STUFF));
    // a packet cut short by seven ones leaves a partial CRC and partial bytes
    if (e.fault != FAULT_STUFF) begin
      check_value("crc16_error_o", 32'(got_crc_err),
                  32'(pid_ok && is_data && e.fault == FAULT_CRC));
      check_value("rx_data_put_o count", 32'(got_bytes.size()), 32'(exp_bytes.size()));
      for (int k = 0; k < exp_bytes.size() && k < got_bytes.size(); k++) begin
        check_value($sformatf("rx_data_o[%0d]", k), 32'(got_bytes[k]), 32'(exp_bytes[k]));
      end
    end
  endtask

  function automatic longint table_bits();
    longint total;
    total = 0;
    for (int i = 0; i < int'(NUM_PKTS); i++) begin
      total += 8 + 8 + 8 * pkt_table[i].len + 3 + IDLE_BITS;
      if (pkt_table[i].pid[1:0] == 2'b11) begin
        total += 16;
      end
    end
    return total;
  endfunction

  initial begin : watchdog
    longint limit_ns;
    wait (table_loaded);
    // each bit lasts 400 ns and the margin covers reset, stuffed bits and waits
    limit_ns = table_bits() * 400 + 60000;
    #(limit_ns);
    $display("timeout: the packet table did not finish within %0d ns", limit_ns);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    usb_dp_i     = 1'b1;
    usb_dn_i     = 1'b0;
    line_level   = LINE_J;
    errors       = 0;
    table_loaded = 1'b0;
    clear_results();
    void'($urandom(SEED));
    load_table();
    table_loaded = 1'b1;
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    repeat (IDLE_BITS) drive_symbol(LINE_J);
    for (int i = 0; i < int'(NUM_PKTS); i++) begin
      build_packet(pkt_table[i]);
      clear_results();
      send_packet(pkt_table[i].fault != FAULT_STUFF);
      wait_for_end(i);
      repeat (IDLE_BITS) drive_symbol(LINE_J);
      check_packet(pkt_table[i]);
    end
    $display("run complete: %0d packets, %0d errors", NUM_PKTS, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- source/usb_fs_rx_top.sv
// full-speed receive chain, usb_dp_i and usb_dn_i must already be synchronous
// the pair to output latency varies, pkt_end_o marks the close of a packet
`timescale 1ns/1ps
`default_nettype none

module usb_fs_rx_top
  import usb_line_pkg::*;
  import usb_pkt_pkg::*;
#(
  parameter int unsigned CLKS_PER_BIT = usb_line_pkg::CLKS_PER_BIT
) (
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  input  wire logic         usb_dp_i,
  input  wire logic         usb_dn_i,
  output logic              bit_strobe_o,
  output logic              pkt_start_o,
  output logic              pkt_end_o,
  output usb_pid_e          pid_o,
  output logic              valid_pid_o,
  output logic              valid_packet_o,
  output logic              rx_data_put_o,
  output logic [BYTE_W-1:0] rx_data_o,
  output logic              crc16_error_o,
  output logic              pid_error_o,
  output logic              bitstuff_error_o
);

  line_state_e line_state;
  logic        sample;

  usb_bit_if u_bits ();

  usb_line_fsm u_line_fsm (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .usb_dp_i     (usb_dp_i),
    .usb_dn_i     (usb_dn_i),
    .line_state_o (line_state)
  );

  usb_bit_timer #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_bit_timer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .line_state_i (line_state),
    .sample_o     (sample)
  );

  usb_bit_decoder u_bit_decoder (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .line_state_i (line_state),
    .sample_i     (sample),
    .bits         (u_bits.dec),
    .pkt_start_o  (pkt_start_o)
  );

  usb_pkt_checker u_pkt_checker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .bits             (u_bits.chk),
    .pid_o            (pid_o),
    .valid_pid_o      (valid_pid_o),
    .valid_packet_o   (valid_packet_o),
    .rx_data_put_o    (rx_data_put_o),
    .rx_data_o        (rx_data_o),
    .crc16_error_o    (crc16_error_o),
    .pid_error_o      (pid_error_o),
    .bitstuff_error_o (bitstuff_error_o)
  );

  assign bit_strobe_o = sample;
  assign pkt_end_o    = u_bits.pid_end;

endmodule

`default_nettype wire

//--- source/usb_pkt_checker.sv
// PID, length and CRC16 checks plus the byte deserializer
// bytes are put without back-pressure and must be taken on rx_data_put_o
// token packets are never reported valid since their CRC5 is not checked
`timescale 1ns/1ps
`default_nettype none

module usb_pkt_checker
  import usb_pkt_pkg::*;
(
  input  wire logic         clk_i,
  input  wire logic         rst_ni,
  usb_bit_if.chk            bits,
  output usb_pid_e          pid_o,
  output logic              valid_pid_o,
  output logic              valid_packet_o,
  output logic              rx_data_put_o,
  output logic [BYTE_W-1:0] rx_data_o,
  output logic              crc16_error_o,
  output logic              pid_error_o,
  output logic              bitstuff_error_o
);

  localparam int unsigned IDX_W = $clog2(BYTE_W);
  localparam logic [1:0]  TYPE_HANDSHAKE = 2'b10;
  localparam logic [1:0]  TYPE_DATA = 2'b11;

  logic              in_pkt_q;
  logic [BYTE_W-1:0] pid_q;
  logic [IDX_W:0]    pid_cnt_q;
  logic              pid_done;
  logic              pid_ok;
  logic              take_pid;
  logic              take_body;
  logic              byte_last;
  logic [IDX_W-1:0]  bit_idx_q;
  logic [1:0]        byte_cnt_q;
  logic [15:0]       crc_q;
  logic              crc_fb;
  logic              crc_ok;
  logic [BYTE_W-1:0] data_q;
  logic              is_data;
  logic              is_handshake;
  logic              hs_len_ok;
  logic              data_len_ok;

  // the first eight bits are the PID, everything after it is packet body
  assign pid_done  = pid_cnt_q[IDX_W];
  assign take_pid  = bits.bit_valid && in_pkt_q && !pid_done;
  assign take_body = bits.bit_valid && in_pkt_q && pid_done;
  assign byte_last = (bit_idx_q == IDX_W'(BYTE_W - 1));

  ////////////////////////////////////////
  // PID capture and body counters
  ////////////////////////////////////////

  // byte_cnt_q saturates at two, which is all the length checks need
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_pkt_q      <= 1'b0;
      pid_q         <= '0;
      pid_cnt_q     <= '0;
      bit_idx_q     <= '0;
      byte_cnt_q    <= '0;
      rx_data_put_o <= 1'b0;
    end else begin
      if (bits.pid_start) begin
        in_pkt_q   <= 1'b1;
        pid_cnt_q  <= '0;
        bit_idx_q  <= '0;
        byte_cnt_q <= '0;
      end else begin
        if (bits.pid_end) begin
          in_pkt_q <= 1'b0;
        end
        // the PID arrives LSB first like every other byte
        if (take_pid) begin
          pid_q     <= {bits.bit_data, pid_q[BYTE_W-1:1]};
          pid_cnt_q <= pid_cnt_q + 1'b1;
        end
        if (take_body) begin
          bit_idx_q <= byte_last ? '0 : bit_idx_q + 1'b1;
          if (byte_last && (byte_cnt_q != 2'd2)) begin
            byte_cnt_q <= byte_cnt_q + 1'b1;
          end
        end
      end
      rx_data_put_o <= take_body && byte_last;
    end
  end

  ////////////////////////////////////////
  // CRC16 and deserializer
  ////////////////////////////////////////

  // the CRC covers the body including the CRC bytes themselves, so a good
  // packet leaves the fixed residue behind
  assign crc_fb = bits.bit_data ^ crc_q[15];

  always_ff @(posedge clk_i) begin
    if (bits.pid_start) begin
      crc_q <= CRC16_INIT;
    end else if (take_body) begin
      crc_q <= {crc_q[14:0], 1'b0} ^ (crc_fb ? CRC16_POLY : 16'h0000);
    end
    if (take_body) begin
      data_q <= {bits.bit_data, data_q[BYTE_W-1:1]};
    end
  end

  assign rx_data_o = data_q;
  assign pid_o     = usb_pid_e'(pid_q[3:0]);

  // the upper nibble must be the complement of the lower one
  assign pid_ok       = pid_done && (pid_q[7:4] == ~pid_q[3:0]);
  assign is_data      = (pid_q[1:0] == TYPE_DATA);
  assign is_handshake = (pid_q[1:0] == TYPE_HANDSHAKE);
  assign crc_ok       = (crc_q == CRC16_RESIDUE);
  assign hs_len_ok    = (byte_cnt_q == 2'd0) && (bit_idx_q == '0);
  assign data_len_ok  = (byte_cnt_q == 2'd2) && (bit_idx_q == '0);

  assign valid_pid_o    = pid_ok;
  assign valid_packet_o = pid_ok && !bits.stuff_err &&
                          ((is_handshake && hs_len_ok) || (is_data && data_len_ok && crc_ok));

  // error flags only pulse on the closing cycle of a packet
  assign crc16_error_o    = bits.pid_end && pid_ok && is_data && !crc_ok;
  assign pid_error_o      = bits.pid_end && !pid_ok;
  assign bitstuff_error_o = bits.pid_end && bits.stuff_err;

  // the decoder never closes a packet right behind a data bit
  a_put_in_packet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_data_put_o |-> in_pkt_q && !bits.pid_end);

endmodule

`default_nettype wire

//--- source/usb_bit_decoder.sv
// framing, NRZI decode and unstuffing on the sampled symbol stream
// the stuffing run is counted from the first bit after the sync
// after a stuffing error no new sync is taken until the line shows SE0
`timescale 1ns/1ps
`default_nettype none

module usb_bit_decoder
  import usb_line_pkg::*;
(
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire line_state_e line_state_i,
  input  wire logic        sample_i,
  usb_bit_if.dec           bits,
  output logic             pkt_start_o
);

  localparam int unsigned HIST_W = $bits(SYNC_PATTERN);
  localparam int unsigned ONES_W = $clog2(MAX_ONES + 1);
  localparam logic [1:0]  SYM_SE0 = 2'(SE0);
  localparam logic [1:0]  SYM_K = 2'(DK);
  localparam logic [1:0]  SYM_J = 2'(DJ);

  logic [HIST_W-1:0] hist_q;
  logic [HIST_W-1:0] hist_next;
  logic [1:0]        sym;
  logic              in_pkt_q;
  logic              wait_se0_q;
  logic [ONES_W-1:0] ones_q;
  logic              see_sop;
  logic              see_sync;
  logic              see_eop;
  logic              raw_valid;
  logic              raw_bit;
  logic              stuffed;
  logic              seventh_one;

  ////////////////////////////////////////
  // packet framing
  ////////////////////////////////////////

  // the newest symbol enters at the bottom of the history
  assign sym       = line_state_i[1:0];
  assign hist_next = {hist_q[HIST_W-3:0], sym};

  // start of sync is the first K that follows idle J
  assign see_sop  = sample_i && !in_pkt_q && !wait_se0_q &&
                    (hist_next[5:0] == {SYM_J, SYM_J, SYM_K});
  assign see_sync = sample_i && !in_pkt_q && !wait_se0_q && (hist_next == SYNC_PATTERN);

  // end of packet on two SE0 bits in a row or on seven ones
  assign see_eop = sample_i && in_pkt_q &&
                   ((hist_next[3:0] == {SYM_SE0, SYM_SE0}) || seventh_one);

  ////////////////////////////////////////
  // NRZI decode and unstuffing
  ////////////////////////////////////////

  // a bit needs a K or J now and on the bit before, so the first SE0 of
  // the EOP produces nothing
  assign raw_valid = sample_i && in_pkt_q && (sym != SYM_SE0) && (hist_q[1:0] != SYM_SE0);
  // no change on the line means a one
  assign raw_bit = (sym == hist_q[1:0]);

  // the zero after a full run of ones is the stuffed bit and is dropped
  assign stuffed     = raw_valid && !raw_bit && (ones_q == ONES_W'(MAX_ONES));
  assign seventh_one = raw_valid && raw_bit && (ones_q == ONES_W'(MAX_ONES));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hist_q         <= {(HIST_W / 2){SYM_K}};
      in_pkt_q       <= 1'b0;
      wait_se0_q     <= 1'b0;
      ones_q         <= '0;
      bits.bit_valid <= 1'b0;
      bits.pid_start <= 1'b0;
      bits.pid_end   <= 1'b0;
      bits.stuff_err <= 1'b0;
      pkt_start_o    <= 1'b0;
    end else begin
      if (sample_i) begin
        hist_q <= hist_next;
      end
      if (see_sync) begin
        in_pkt_q <= 1'b1;
      end else if (see_eop) begin
        in_pkt_q <= 1'b0;
      end
      // the rest of a broken packet is ignored until its EOP has passed
      if (seventh_one) begin
        wait_se0_q <= 1'b1;
      end else if (sample_i && !in_pkt_q && (sym == SYM_SE0)) begin
        wait_se0_q <= 1'b0;
      end
      if (see_sync) begin
        ones_q <= '0;
      end else if (raw_valid && !raw_bit) begin
        ones_q <= '0;
      end else if (raw_valid && !seventh_one) begin
        ones_q <= ones_q + 1'b1;
      end
      bits.bit_valid <= raw_valid && !stuffed && !seventh_one;
      bits.pid_start <= see_sync;
      bits.pid_end   <= see_eop;
      pkt_start_o    <= see_sop;
      if (see_sync) begin
        bits.stuff_err <= 1'b0;
      end else if (seventh_one) begin
        bits.stuff_err <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (raw_valid) begin
      bits.bit_data <= raw_bit;
    end
  end

endmodule

`default_nettype wire

//--- source/usb_bit_timer.sv
// bit phase recovery from the DT state of the line FSM
// needs CLKS_PER_BIT of at least 3 and SAMPLE_PHASE below CLKS_PER_BIT
`timescale 1ns/1ps
`default_nettype none

module usb_bit_timer
  import usb_line_pkg::*;
#(
  parameter int unsigned CLKS_PER_BIT = usb_line_pkg::CLKS_PER_BIT
) (
  input  wire logic        clk_i,
  input  wire logic        rst_ni,
  input  wire line_state_e line_state_i,
  output logic             sample_o
);

  localparam int unsigned PHASE_W = $clog2(CLKS_PER_BIT);

  logic [PHASE_W-1:0] phase_q;

  // every transition restarts the bit, and between transitions the phase
  // free-runs so long runs of one symbol still give one sample per bit
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= '0;
    end else if (line_state_i == DT) begin
      phase_q <= '0;
    end else if (phase_q == PHASE_W'(CLKS_PER_BIT - 1)) begin
      phase_q <= '0;
    end else begin
      phase_q <= phase_q + 1'b1;
    end
  end

  // sampling away from the edge leaves room for DT and receiver skew
  assign sample_o = (phase_q == PHASE_W'(SAMPLE_PHASE));

  a_phase_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    phase_q < CLKS_PER_BIT);

endmodule

`default_nettype wire

//--- source/usb_line_fsm.sv
// recovers the line state from a D+/D- pair that is already synchronous to clk_i
// SE1 is illegal on the bus and is read as SE0 so the packet fails its checks
`timescale 1ns/1ps
`default_nettype none

module usb_line_fsm
  import usb_line_pkg::*;
(
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  usb_dp_i,
  input  wire logic  usb_dn_i,
  output line_state_e line_state_o
);

  line_state_e state_q;
  line_state_e state_d;
  logic [1:0]  pair;

  assign pair = {usb_dp_i, usb_dn_i};

  // one of the two wires may switch a sample before the other, so any
  // change first parks the FSM in DT for a clock and the pair is only
  // decoded once both wires have had time to settle
  always_comb begin
    state_d = state_q;
    if (state_q == DT) begin
      unique case (pair)
        2'b01:   state_d = DK;
        2'b10:   state_d = DJ;
        default: state_d = SE0;
      endcase
    end else if (pair != state_q[1:0]) begin
      state_d = DT;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SE0;
    end else begin
      state_q <= state_d;
    end
  end

  assign line_state_o = state_q;

  // the bit timer realigns on DT, a stuck DT would hold the phase at zero
  a_dt_single_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q == DT |=> state_q != DT);

endmodule

`default_nettype wire

//--- source/usb_bit_if.sv
// decoded bit stream between the bit decoder and the packet checker
// there is no back-pressure, every signal is a plain pulse or level
`timescale 1ns/1ps
`default_nettype none

interface usb_bit_if;

  logic bit_valid;  // one pulse per unstuffed data bit
  logic bit_data;   // decoded bit, qualified by bit_valid
  logic pid_start;  // first cycle of a packet, right after the sync
  logic pid_end;    // cycle on which the packet closes
  logic stuff_err;  // seven ones were seen, held until the next pid_start

  // the decoder produces the stream
  modport dec (output bit_valid, bit_data, pid_start, pid_end, stuff_err);

  // the checker only consumes it
  modport chk (input bit_valid, bit_data, pid_start, pid_end, stuff_err);

endinterface

`default_nettype wire

//--- source/usb_pkt_pkg.sv
// packet level definitions: PID codes, CRC16 constants and the byte width
// ERR shares its code with PRE and is therefore not listed separately
`default_nettype none

package usb_pkt_pkg;

  // the low two bits give the packet type: 01 token, 11 data, 10 handshake
  typedef enum logic [3:0] {
    PID_RSVD  = 4'b0000,
    PID_OUT   = 4'b0001,
    PID_ACK   = 4'b0010,
    PID_DATA0 = 4'b0011,
    PID_PING  = 4'b0100,
    PID_SOF   = 4'b0101,
    PID_NYET  = 4'b0110,
    PID_DATA2 = 4'b0111,
    PID_SPLIT = 4'b1000,
    PID_IN    = 4'b1001,
    PID_NAK   = 4'b1010,
    PID_DATA1 = 4'b1011,
    PID_PRE   = 4'b1100,
    PID_SETUP = 4'b1101,
    PID_STALL = 4'b1110,
    PID_MDATA = 4'b1111
  } usb_pid_e;

  localparam int unsigned BYTE_W = 8;

  // x^16 + x^15 + x^2 + 1, run over the bits in line order
  localparam logic [15:0] CRC16_POLY    = 16'h8005;
  localparam logic [15:0] CRC16_INIT    = 16'hFFFF;
  localparam logic [15:0] CRC16_RESIDUE = 16'h800D;

endpackage

`default_nettype wire

//--- source/usb_line_pkg.sv
// line level definitions for a full-speed receiver sampled at 48 MHz
// symbol encodings keep D+ in bit 1 and D- in bit 0 for K and J
`default_nettype none

package usb_line_pkg;

  // settled line symbols plus the one-cycle transition state
  typedef enum logic [2:0] {
    SE0 = 3'b000,
    DK  = 3'b001,
    DJ  = 3'b010,
    DT  = 3'b100
  } line_state_e;

  // full speed is 12 Mbit/s, so a 48 MHz sample clock gives four clocks per bit
  localparam int unsigned CLKS_PER_BIT = 4;

  // phase at which a settled bit is taken, counted from the realigning transition
  localparam int unsigned SAMPLE_PHASE = 1;

  // last six symbols of a sync, oldest in the top bits: K J K J K K
  localparam logic [11:0] SYNC_PATTERN = 12'b01_10_01_10_01_01;

  // a zero is stuffed after this many consecutive ones
  localparam int unsigned MAX_ONES = 6;

endpackage

`default_nettype wire
